/* verilog.f */
rtl/mem_pkg.sv
rtl/apb_loader_port.sv
rtl/mem_arbiter.sv
rtl/data_ram.sv
rtl/io_mapper.sv
rtl/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_mem_subsystem
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int    RAM_AW      = 10;
    localparam int    RAM_DEPTH   = 1 << RAM_AW;
    localparam addr_t RAM_BYTES   = addr_t'(RAM_DEPTH) << 2;
    localparam word_t SWITCH_MASK = word_t'((1 << SWITCH_CNT) - 1);
    localparam int    APB_TXNS    = 800;
    localparam int    CPU_TXNS    = 1200;
    localparam int    WAIT_LIMIT  = 16;
    localparam int    RUN_LIMIT   = 40000;

    logic                  clk_cpu;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    addr_t                 paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  cpu_req;
    logic                  cpu_write;
    addr_t                 cpu_addr;
    word_t                 cpu_wdata;
    logic                  cpu_stall;
    logic                  cpu_rvalid;
    word_t                 cpu_rdata;
    logic [SWITCH_CNT-1:0] switches;
    word_t                 display;

    integer seed;

    // reference model of the ram and the display register
    word_t model_mem [RAM_DEPTH];
    bit    model_known [RAM_DEPTH];
    word_t model_display;

    // high while the loader is in the cycle that takes the ram
    logic  loader_req_cycle;

    mem_subsystem_top #(
        .RAM_ADDR_WIDTH (RAM_AW)
    ) uut (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cpu_req    (cpu_req),
        .cpu_write  (cpu_write),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_stall  (cpu_stall),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .switches   (switches),
        .display    (display)
    );

    initial clk_cpu = 1'b0;

    always #5 clk_cpu = ~clk_cpu;

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic expect_reset_state();
        check_flag("pready", pready, 1'b0);
        check_flag("pslverr", pslverr, 1'b0);
        check_flag("cpu_stall", cpu_stall, 1'b0);
        check_flag("cpu_rvalid", cpu_rvalid, 1'b0);
        check_word("display", display, '0);
    endtask

    function automatic word_t next_random();
        return $random(seed);
    endfunction

    // mostly a small hot window so both peers hit the same words
    function automatic addr_t ram_addr_from(input word_t r);
        if (r[31:29] < 3'd5) begin
            return addr_t'(r[3:0]) << 2;
        end
        return addr_t'(r[RAM_AW-1:0]) << 2;
    endfunction

    function automatic addr_t loader_addr_from(input word_t r);
        if (r[31:29] == 3'd7) begin
            if (r[28]) begin
                return IO_BASE | (r & 32'h0000_03FC);
            end
            // out-of-range addresses alias onto the hot words
            return RAM_BYTES + (r & 32'h00FF_F000) + (addr_t'(r[3:0]) << 2);
        end
        return ram_addr_from(r);
    endfunction

    function automatic addr_t other_io_addr_from(input word_t r);
        return IO_BASE + 32'h8 + (addr_t'(r[6:0]) << 2);
    endfunction

    function automatic bit apb_addr_ok(input addr_t a);
        return (a < IO_BASE) && ((a >> 2) < addr_t'(RAM_DEPTH));
    endfunction

    task automatic apb_transfer(input logic write, input addr_t addr, input word_t wdata);
        logic              valid;
        logic [RAM_AW-1:0] idx;
        int                waits;
        word_t             exp_rdata;
        logic              exp_known;

        valid     = apb_addr_ok(addr);
        idx       = addr[RAM_AW+1:2];
        exp_rdata = '0;
        exp_known = 1'b0;

        @(posedge clk_cpu);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(negedge clk_cpu);
        check_flag("pready", pready, 1'b0);

        // first access cycle
        @(posedge clk_cpu);
        penable <= 1'b1;
        loader_req_cycle = valid;
        @(negedge clk_cpu);
        if (valid && write) begin
            model_mem[idx]   = wdata;
            model_known[idx] = 1'b1;
        end else if (valid) begin
            exp_rdata = model_mem[idx];
            exp_known = model_known[idx];
        end

        waits = 0;
        while (!pready && waits < WAIT_LIMIT) begin
            @(posedge clk_cpu);
            loader_req_cycle = 1'b0;
            @(negedge clk_cpu);
            waits++;
        end
        if (!pready) begin
            $display("timeout: pready did not rise within %0d access cycles", WAIT_LIMIT);
            stop_on_failure();
        end
        check_word("apb wait states", word_t'(waits), (valid && !write) ? 32'd1 : 32'd0);
        check_flag("pslverr", pslverr, !valid);
        if (exp_known) begin
            check_word("prdata", prdata, exp_rdata);
        end

        @(posedge clk_cpu);
        loader_req_cycle = 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic cpu_access(input logic write, input addr_t addr, input word_t wdata);
        logic              is_ram;
        logic [RAM_AW-1:0] idx;
        int                stalls;
        int                lat;
        word_t             exp_rdata;
        logic              exp_known;
        word_t             sw_value;

        is_ram    = (addr < IO_BASE);
        idx       = addr[RAM_AW+1:2];
        exp_rdata = '0;
        exp_known = 1'b1;
        sw_value  = next_random();

        @(posedge clk_cpu);
        cpu_req   <= 1'b1;
        cpu_write <= write;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        switches  <= sw_value[SWITCH_CNT-1:0];

        stalls = 0;
        @(negedge clk_cpu);
        check_flag("cpu_stall", cpu_stall, is_ram & loader_req_cycle);
        while (cpu_stall && stalls < WAIT_LIMIT) begin
            @(posedge clk_cpu);
            @(negedge clk_cpu);
            stalls++;
            check_flag("cpu_stall", cpu_stall, is_ram & loader_req_cycle);
        end
        if (cpu_stall) begin
            $display("timeout: cpu_stall stayed high for %0d cycles", WAIT_LIMIT);
            stop_on_failure();
        end
        check_flag("cpu_rvalid", cpu_rvalid, 1'b0);

        // accepted in this cycle
        if (is_ram && write) begin
            model_mem[idx]   = wdata;
            model_known[idx] = 1'b1;
        end else if (is_ram) begin
            exp_rdata = model_mem[idx];
            exp_known = model_known[idx];
        end else if (!write && addr == SWITCH_ADDR) begin
            exp_rdata = sw_value & SWITCH_MASK;
        end else if (write && addr == DISPLAY_ADDR) begin
            model_display = wdata;
        end

        @(posedge clk_cpu);
        cpu_req <= 1'b0;
        lat = 1;
        @(negedge clk_cpu);
        if (!write) begin
            while (!cpu_rvalid && lat < WAIT_LIMIT) begin
                @(posedge clk_cpu);
                @(negedge clk_cpu);
                lat++;
            end
            if (!cpu_rvalid) begin
                $display("timeout: cpu_rvalid did not rise within %0d cycles", WAIT_LIMIT);
                stop_on_failure();
            end
            check_word("cpu read latency", word_t'(lat), 32'd1);
            if (exp_known) begin
                check_word("cpu_rdata", cpu_rdata, exp_rdata);
            end
        end else begin
            check_flag("cpu_rvalid", cpu_rvalid, 1'b0);
        end
        check_word("display", display, model_display);
    endtask

    task automatic run_loader();
        word_t r;
        addr_t a;
        word_t d;

        for (int n = 0; n < APB_TXNS; n++) begin
            r = next_random();
            a = loader_addr_from(next_random());
            d = next_random();
            repeat (int'(r[1:0])) @(posedge clk_cpu);
            apb_transfer(r[2], a, d);
        end
    endtask

    task automatic run_cpu();
        word_t r;
        word_t ar;
        word_t d;

        for (int n = 0; n < CPU_TXNS; n++) begin
            r  = next_random();
            ar = next_random();
            d  = next_random();
            repeat (r[2] ? 0 : int'(r[1:0])) @(posedge clk_cpu);
            case (r[5:3])
                3'd0, 3'd1: cpu_access(1'b0, ram_addr_from(ar), d);
                3'd2, 3'd3: cpu_access(1'b1, ram_addr_from(ar), d);
                3'd4:       cpu_access(1'b0, SWITCH_ADDR, d);
                3'd5:       cpu_access(1'b1, DISPLAY_ADDR, d);
                3'd6:       cpu_access(1'b0, other_io_addr_from(ar), d);
                default:    cpu_access(1'b1, other_io_addr_from(ar), d);
            endcase
        end
    endtask

    initial begin : watchdog
        repeat (RUN_LIMIT) @(posedge clk_cpu);
        $display("the run did not finish within %0d clock cycles", RUN_LIMIT);
        stop_on_failure();
    end

    initial begin
        seed      = 32'h24ca;
        rst_n     <= 1'b0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        cpu_req   <= 1'b0;
        cpu_write <= 1'b0;
        cpu_addr  <= '0;
        cpu_wdata <= '0;
        switches  <= '0;
        loader_req_cycle = 1'b0;
        model_display    = '0;

        for (int i = 0; i < 5; i++) begin
            @(negedge clk_cpu);
            expect_reset_state();
        end
        @(posedge clk_cpu);
        rst_n <= 1'b1;
        @(negedge clk_cpu);
        expect_reset_state();

        // loader and cpu run side by side
        fork
            run_loader();
            run_cpu();
        join

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top import mem_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                  clk_cpu,
    input  wire logic                  rst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire addr_t                 paddr,
    input  wire word_t                 pwdata,
    output word_t                      prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire logic                  cpu_req,
    input  wire logic                  cpu_write,
    input  wire addr_t                 cpu_addr,
    input  wire word_t                 cpu_wdata,
    output logic                       cpu_stall,
    output logic                       cpu_rvalid,
    output word_t                      cpu_rdata,
    input  wire logic [SWITCH_CNT-1:0] switches,
    output word_t                      display
);

    // loader request channel
    logic                      ld_req;
    logic                      ld_write;
    logic [RAM_ADDR_WIDTH-1:0] ld_addr;
    word_t                     ld_wdata;

    // cpu request channel
    logic                      cp_req;
    logic                      cp_write;
    logic [RAM_ADDR_WIDTH-1:0] cp_addr;
    word_t                     cp_wdata;
    logic                      cp_grant;
    logic                      cp_rvalid;

    word_t                     arb_rdata;

    // single ram port
    logic                      ram_en;
    logic                      ram_we;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    word_t                     ram_wdata;
    word_t                     ram_rdata;

    apb_loader_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_apb_loader_port (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .ld_req         (ld_req),
        .ld_write       (ld_write),
        .ld_addr        (ld_addr),
        .ld_wdata       (ld_wdata),
        .ld_rdata       (arb_rdata)
    );

    mem_arbiter #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_mem_arbiter (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .ld_req         (ld_req),
        .ld_write       (ld_write),
        .ld_addr        (ld_addr),
        .ld_wdata       (ld_wdata),
        .cp_req         (cp_req),
        .cp_write       (cp_write),
        .cp_addr        (cp_addr),
        .cp_wdata       (cp_wdata),
        .ram_rdata      (ram_rdata),
        .cp_grant       (cp_grant),
        .cp_rvalid      (cp_rvalid),
        .rdata          (arb_rdata),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    data_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_data_ram (
        .clk_cpu        (clk_cpu),
        .en             (ram_en),
        .we             (ram_we),
        .addr           (ram_addr),
        .wdata          (ram_wdata),
        .rdata          (ram_rdata)
    );

    io_mapper #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_io_mapper (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .cpu_write      (cpu_write),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .switches       (switches),
        .cp_grant       (cp_grant),
        .cp_rvalid      (cp_rvalid),
        .ram_rdata      (arb_rdata),
        .cpu_stall      (cpu_stall),
        .cpu_rvalid     (cpu_rvalid),
        .cpu_rdata      (cpu_rdata),
        .display        (display),
        .cp_req         (cp_req),
        .cp_write       (cp_write),
        .cp_addr        (cp_addr),
        .cp_wdata       (cp_wdata)
    );

endmodule

`default_nettype wire

/* rtl/io_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module io_mapper import mem_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                      clk_cpu,
    input  wire logic                      rst_n,
    input  wire logic                      cpu_req,
    input  wire logic                      cpu_write,
    input  wire addr_t                     cpu_addr,
    input  wire word_t                     cpu_wdata,
    input  wire logic [SWITCH_CNT-1:0]     switches,
    input  wire logic                      cp_grant,
    input  wire logic                      cp_rvalid,
    input  wire word_t                     ram_rdata,
    output logic                           cpu_stall,
    output logic                           cpu_rvalid,
    output word_t                          cpu_rdata,
    output word_t                          display,
    output logic                           cp_req,
    output logic                           cp_write,
    output logic [RAM_ADDR_WIDTH-1:0]      cp_addr,
    output word_t                          cp_wdata
);

    logic  is_io;
    logic  io_access;
    logic  io_rvalid;
    word_t io_rdata;

    assign is_io     = (cpu_addr >= IO_BASE);
    assign io_access = cpu_req & is_io;

    // ram side goes through the arbiter
    assign cp_req    = cpu_req & ~is_io;
    assign cp_write  = cpu_write;
    assign cp_addr   = cpu_addr[RAM_ADDR_WIDTH+1:2];
    assign cp_wdata  = cpu_wdata;

    // only a lost ram cycle holds the cpu, i/o never waits
    assign cpu_stall = cp_req & ~cp_grant;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            display   <= '0;
            io_rvalid <= 1'b0;
        end else begin
            io_rvalid <= io_access & ~cpu_write;
            if (io_access && cpu_write && cpu_addr == DISPLAY_ADDR) begin
                display <= cpu_wdata;
            end
        end
    end

    // unmapped i/o reads give zero
    always_ff @(posedge clk_cpu) begin
        if (io_access && !cpu_write) begin
            io_rdata <= (cpu_addr == SWITCH_ADDR) ? word_t'(switches) : '0;
        end
    end

    // at most one of the two returns per cycle
    assign cpu_rvalid = cp_rvalid | io_rvalid;
    assign cpu_rdata  = io_rvalid ? io_rdata : ram_rdata;

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import mem_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                      clk_cpu,
    input  wire logic                      en,
    input  wire logic                      we,
    input  wire logic [RAM_ADDR_WIDTH-1:0] addr,
    input  wire word_t                     wdata,
    output word_t                          rdata
);

    localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

    word_t mem [DEPTH];

    // output register only moves on a read
    always_ff @(posedge clk_cpu) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                      clk_cpu,
    input  wire logic                      rst_n,
    input  wire logic                      ld_req,
    input  wire logic                      ld_write,
    input  wire logic [RAM_ADDR_WIDTH-1:0] ld_addr,
    input  wire word_t                     ld_wdata,
    input  wire logic                      cp_req,
    input  wire logic                      cp_write,
    input  wire logic [RAM_ADDR_WIDTH-1:0] cp_addr,
    input  wire word_t                     cp_wdata,
    input  wire word_t                     ram_rdata,
    output logic                           cp_grant,
    output logic                           cp_rvalid,
    output word_t                          rdata,
    output logic                           ram_en,
    output logic                           ram_we,
    output logic [RAM_ADDR_WIDTH-1:0]      ram_addr,
    output word_t                          ram_wdata
);

    logic cp_read_q;

    // loader always first, cpu only gets idle cycles
    assign cp_grant = cp_req & ~ld_req;

    assign ram_en = ld_req | cp_req;

    always_comb begin
        if (ld_req) begin
            ram_we    = ld_write;
            ram_addr  = ld_addr;
            ram_wdata = ld_wdata;
        end else begin
            ram_we    = cp_write;
            ram_addr  = cp_addr;
            ram_wdata = cp_wdata;
        end
    end

    // cpu read issued last cycle
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            cp_read_q <= 1'b0;
        end else begin
            cp_read_q <= cp_grant & ~cp_write;
        end
    end

    assign cp_rvalid = cp_read_q;

    // both peers see the same return word
    assign rdata = ram_rdata;

endmodule

`default_nettype wire

/* rtl/apb_loader_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_loader_port import mem_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                      clk_cpu,
    input  wire logic                      rst_n,
    input  wire logic                      psel,
    input  wire logic                      penable,
    input  wire logic                      pwrite,
    input  wire addr_t                     paddr,
    input  wire word_t                     pwdata,
    output word_t                          prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           ld_req,
    output logic                           ld_write,
    output logic [RAM_ADDR_WIDTH-1:0]      ld_addr,
    output word_t                          ld_wdata,
    input  wire word_t                     ld_rdata
);

    logic access_phase;
    logic addr_valid;
    logic wait_flag;

    assign access_phase = psel & penable;

    // word index must fit the ram and stay below the i/o window
    assign addr_valid = (paddr < IO_BASE) &&
                        ((paddr >> 2) < (addr_t'(1) << RAM_ADDR_WIDTH));

    // one request per transfer, in the first access cycle
    assign ld_req   = access_phase & addr_valid & ~wait_flag;
    assign ld_write = pwrite;
    assign ld_addr  = paddr[RAM_ADDR_WIDTH+1:2];
    assign ld_wdata = pwdata;

    // set while the ram read is in flight
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            wait_flag <= 1'b0;
        end else begin
            wait_flag <= ld_req & ~ld_write;
        end
    end

    // writes and errors finish at once, reads one cycle later
    assign pready  = access_phase & (~addr_valid | pwrite | wait_flag);
    assign pslverr = access_phase & ~addr_valid;

    // ram output register already holds the word during the wait state
    assign prdata = wait_flag ? ld_rdata : '0;

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // one processor data word
    typedef logic [31:0] word_t;

    // byte address as seen by the cpu and the loader
    typedef logic [31:0] addr_t;

    // everything from here upward is memory-mapped i/o
    localparam addr_t IO_BASE = 32'hFFFF_FC00;

    // read-only switch inputs
    localparam addr_t SWITCH_ADDR = 32'hFFFF_FC00;

    // write-only display register
    localparam addr_t DISPLAY_ADDR = 32'hFFFF_FC04;

    localparam int SWITCH_CNT = 8;

endpackage

`default_nettype wire
